// ==== bp_defines.svh ====
// branch predictor sizes, include in any file that needs index, history, queue or counter widths
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

`define BP_IDX_W        4   // table index, 16 entries
`define BP_HIST_W       4   // local history bits, prediction rule assumes 4
`define BP_QUEUE_DEPTH  4   // update queue entries, power of two
`define BP_CNT_W        16  // mispredict counter, wraps

`endif

// ==== bp_pkg.sv ====
// shared branch predictor types and the history to prediction rule, import where needed
`include "bp_defines.svh"

package bp_pkg;

    // one resolved branch as reported by execute
    typedef struct packed {
        logic                 valid;
        logic [`BP_IDX_W-1:0] idx;
        logic                 predicted;
        logic                 taken;
    } bp_resolve_t;

    // one pending history shift for the table
    typedef struct packed {
        logic [`BP_IDX_W-1:0] idx;
        logic                 taken;
    } bp_update_t;

    // bit 0 of hist is the newest outcome
    function automatic logic bp_predict(input logic [`BP_HIST_W-1:0] hist);
        logic [2:0] ones;
        logic       pred;
        ones = 3'(hist[0]) + 3'(hist[1]) + 3'(hist[2]) + 3'(hist[3]);
        case (hist)
            // repeating patterns that lead into a taken branch
            4'b1111,
            4'b0101,
            4'b1100,
            4'b1001: begin
                pred = 1'b1;
            end
            // patterns that lead into a not taken branch
            4'b0000,
            4'b1010,
            4'b0110,
            4'b0011: begin
                pred = 1'b0;
            end
            default: begin
                pred = (ones >= 3'd3); // majority of recent outcomes
            end
        endcase
        return pred;
    endfunction

endpackage

// ==== branch_resolve.sv ====
// resolve stage: registers two execute slots, packs them into queue pushes, counts mispredicts
`timescale 1ns/1ps
`include "bp_defines.svh"

module branch_resolve
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  bp_resolve_t          res0,
    input  bp_resolve_t          res1,
    output bp_update_t           push0,
    output bp_update_t           push1,
    output logic                 push0_en,
    output logic                 push1_en,
    output logic [1:0]           mispredict,
    output logic [`BP_CNT_W-1:0] mispredict_count
);

    bp_update_t           slot0_upd;
    bp_update_t           slot1_upd;
    bp_update_t           push0_d;
    bp_update_t           push1_d;
    logic                 push0_en_d;
    logic                 push1_en_d;
    logic [1:0]           miss_d;
    logic [`BP_CNT_W-1:0] miss_add;

    assign slot0_upd = '{idx: res0.idx, taken: res0.taken};
    assign slot1_upd = '{idx: res1.idx, taken: res1.taken};

    // compact valid slots so push0 always carries the older one
    always_comb begin
        push0_d    = slot0_upd;
        push1_d    = slot1_upd;
        push0_en_d = res0.valid | res1.valid;
        push1_en_d = res0.valid & res1.valid;
        if (!res0.valid) begin
            push0_d = slot1_upd; // slot 1 alone moves down
        end
    end

    // mispredict stays per slot, not compacted
    assign miss_d[0] = res0.valid & (res0.predicted ^ res0.taken);
    assign miss_d[1] = res1.valid & (res1.predicted ^ res1.taken);
    assign miss_add  = `BP_CNT_W'(miss_d[0]) + `BP_CNT_W'(miss_d[1]);

    always_ff @(posedge clk) begin
        if (reset) begin
            push0_en         <= 1'b0;
            push1_en         <= 1'b0;
            mispredict       <= 2'b00;
            mispredict_count <= '0;
        end else begin
            push0_en         <= push0_en_d;
            push1_en         <= push1_en_d;
            mispredict       <= miss_d;
            mispredict_count <= mispredict_count + miss_add; // wraps
        end
    end

    // payload only matters with its strobe
    always_ff @(posedge clk) begin
        push0 <= push0_d;
        push1 <= push1_d;
    end

endmodule

// ==== update_queue.sv ====
// two-in one-out circular buffer between the resolve stage and the history table
`timescale 1ns/1ps
`include "bp_defines.svh"

module update_queue
    import bp_pkg::*;
#(
    parameter int DEPTH = `BP_QUEUE_DEPTH
) (
    input  logic       clk,
    input  logic       reset,
    input  bp_update_t push0,
    input  bp_update_t push1,
    input  logic       push0_en,
    input  logic       push1_en,
    output bp_update_t upd,
    output logic       upd_en,
    output logic       resolve_stall
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    bp_update_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [1:0]       n_push;
    logic [CNT_W:0]   used;

    assign n_push = {1'b0, push0_en} + {1'b0, push1_en};

    // head is always visible, table takes it every cycle
    assign upd    = mem[rd_ptr];
    assign upd_en = (count != '0);

    // entries held plus pushes arriving at the next edge
    assign used          = {1'b0, count} + (CNT_W + 1)'(n_push);
    assign resolve_stall = (used > (CNT_W + 1)'(DEPTH - 2)); // under two free

    always_ff @(posedge clk) begin
        if (push0_en) begin
            mem[wr_ptr] <= push0;
        end
        if (push1_en) begin
            mem[wr_ptr + PTR_W'(push0_en)] <= push1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(n_push); // pointers wrap at DEPTH
            if (upd_en) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count <= count + CNT_W'(n_push) - CNT_W'(upd_en);
        end
    end

endmodule

// ==== history_table.sv ====
// local history table with one fetch and two decode prediction ports and one update port
`timescale 1ns/1ps
`include "bp_defines.svh"

module history_table
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`BP_IDX_W-1:0] fetch_idx,
    input  logic [`BP_IDX_W-1:0] dec0_idx,
    input  logic [`BP_IDX_W-1:0] dec1_idx,
    input  bp_update_t           upd,
    input  logic                 upd_en,
    output logic                 fetch_pred,
    output logic                 dec0_pred,
    output logic                 dec1_pred
);

    localparam int ENTRIES = 1 << `BP_IDX_W;

    logic [`BP_HIST_W-1:0] hist [ENTRIES];
    logic [`BP_HIST_W-1:0] fetch_hist;
    logic [`BP_HIST_W-1:0] dec0_hist;
    logic [`BP_HIST_W-1:0] dec1_hist;
    logic [`BP_HIST_W-1:0] upd_hist;

    // oldest outcome falls off the top
    assign upd_hist = {hist[upd.idx][`BP_HIST_W-2:0], upd.taken};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                hist[i] <= '0; // all not taken
            end
        end else if (upd_en) begin
            hist[upd.idx] <= upd_hist;
        end
    end

    // reads see the table before this cycle's write
    assign fetch_hist = hist[fetch_idx];
    assign dec0_hist  = hist[dec0_idx];
    assign dec1_hist  = hist[dec1_idx];

    assign fetch_pred = bp_predict(fetch_hist);
    assign dec0_pred  = bp_predict(dec0_hist);
    assign dec1_pred  = bp_predict(dec1_hist);

endmodule

// ==== branch_predictor_top.sv ====
// branch direction predictor top: resolve stage feeding the update queue feeding the history table
`timescale 1ns/1ps
`include "bp_defines.svh"

module branch_predictor_top
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  bp_resolve_t          res0,
    input  bp_resolve_t          res1,
    input  logic [`BP_IDX_W-1:0] fetch_idx,
    input  logic [`BP_IDX_W-1:0] dec0_idx,
    input  logic [`BP_IDX_W-1:0] dec1_idx,
    output logic                 fetch_pred,
    output logic                 dec0_pred,
    output logic                 dec1_pred,
    output logic [1:0]           mispredict,
    output logic [`BP_CNT_W-1:0] mispredict_count,
    output logic                 resolve_stall
);

    bp_update_t push0;
    bp_update_t push1;
    logic       push0_en;
    logic       push1_en;
    bp_update_t upd;
    logic       upd_en;

    branch_resolve resolve0 (
        .clk              (clk),
        .reset            (reset),
        .res0             (res0),
        .res1             (res1),
        .push0            (push0),
        .push1            (push1),
        .push0_en         (push0_en),
        .push1_en         (push1_en),
        .mispredict       (mispredict),
        .mispredict_count (mispredict_count)
    );

    update_queue #(
        .DEPTH (`BP_QUEUE_DEPTH)
    ) queue0 (
        .clk           (clk),
        .reset         (reset),
        .push0         (push0),
        .push1         (push1),
        .push0_en      (push0_en),
        .push1_en      (push1_en),
        .upd           (upd),
        .upd_en        (upd_en),
        .resolve_stall (resolve_stall)
    );

    history_table table0 (
        .clk        (clk),
        .reset      (reset),
        .fetch_idx  (fetch_idx),
        .dec0_idx   (dec0_idx),
        .dec1_idx   (dec1_idx),
        .upd        (upd),
        .upd_en     (upd_en),
        .fetch_pred (fetch_pred),
        .dec0_pred  (dec0_pred),
        .dec1_pred  (dec1_pred)
    );

endmodule

// ==== branch_predictor_props.sv ====
// assertions on queue occupancy, reset state and mispredict pulses, bound into the predictor top
`timescale 1ns/1ps
`include "bp_defines.svh"

module branch_predictor_props (
    input logic       clk,
    input logic       reset,
    input logic       push0_en,
    input logic       push1_en,
    input logic       upd_en,
    input logic       res0_valid,
    input logic       res1_valid,
    input logic [1:0] mispredict
);

    localparam int OCC_W = $clog2(`BP_QUEUE_DEPTH + 1) + 1;

    logic [OCC_W-1:0] occ; // entries held in the update queue

    always_ff @(posedge clk) begin
        if (reset) begin
            occ <= '0;
        end else begin
            occ <= occ + OCC_W'(push0_en) + OCC_W'(push1_en) - OCC_W'(upd_en);
        end
    end

    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        (occ == OCC_W'(`BP_QUEUE_DEPTH)) |-> !(push0_en || push1_en))
        else $error("push while the update queue is full");

    a_upd_idle_after_reset: assert property (@(posedge clk) reset |=> !upd_en)
        else $error("upd_en high right after reset");

    // each pulse needs its own slot valid one cycle earlier
    a_miss0_needs_valid: assert property (@(posedge clk) disable iff (reset)
        mispredict[0] |-> $past(res0_valid))
        else $error("mispredict[0] without a valid slot 0");

    a_miss1_needs_valid: assert property (@(posedge clk) disable iff (reset)
        mispredict[1] |-> $past(res1_valid))
        else $error("mispredict[1] without a valid slot 1");

endmodule

bind branch_predictor_top branch_predictor_props props0 (
    .clk        (clk),
    .reset      (reset),
    .push0_en   (push0_en),
    .push1_en   (push1_en),
    .upd_en     (upd_en),
    .res0_valid (res0.valid),
    .res1_valid (res1.valid),
    .mispredict (mispredict)
);

// ==== tb_branch_predictor.sv ====
// testbench for the branch predictor, replays bp_testdata.txt against a local history model
`timescale 1ns/1ps
`include "bp_defines.svh"

module tb_branch_predictor
    import bp_pkg::*;
();

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 10;
    localparam int CYCLES_PER_CMD = 20;
    localparam int ENTRIES        = 1 << `BP_IDX_W;

    logic                 clk;
    logic                 reset;
    bp_resolve_t          res0;
    bp_resolve_t          res1;
    logic [`BP_IDX_W-1:0] fetch_idx;
    logic [`BP_IDX_W-1:0] dec0_idx;
    logic [`BP_IDX_W-1:0] dec1_idx;
    logic                 fetch_pred;
    logic                 dec0_pred;
    logic                 dec1_pred;
    logic [1:0]           mispredict;
    logic [`BP_CNT_W-1:0] mispredict_count;
    logic                 resolve_stall;

    logic [`BP_HIST_W-1:0] model_hist [ENTRIES];
    logic [`BP_CNT_W-1:0]  model_miss;
    string                 cmds [$];
    int                    err_count;
    logic                  loaded;
    logic                  saw_stall; // set while an R line waits
    logic [1:0]            miss_pending; // pulse due for the slots just driven
    logic [1:0]            miss_expect;

    branch_predictor_top dut0 (
        .clk              (clk),
        .reset            (reset),
        .res0             (res0),
        .res1             (res1),
        .fetch_idx        (fetch_idx),
        .dec0_idx         (dec0_idx),
        .dec1_idx         (dec1_idx),
        .fetch_pred       (fetch_pred),
        .dec0_pred        (dec0_pred),
        .dec1_pred        (dec1_pred),
        .mispredict       (mispredict),
        .mispredict_count (mispredict_count),
        .resolve_stall    (resolve_stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // expected direction, bit 0 newest
    function automatic logic model_predict(input logic [3:0] h);
        if (h == 4'b1111 || h == 4'b0101 || h == 4'b1100 || h == 4'b1001) begin
            return 1'b1;
        end
        if (h == 4'b0000 || h == 4'b1010 || h == 4'b0110 || h == 4'b0011) begin
            return 1'b0;
        end
        return ($countones(h) >= 3); // three or more taken
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            err_count++;
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic drive_idle();
        res0 = '0;
        res1 = '0;
    endtask

    task automatic model_update(input bp_resolve_t r);
        if (r.valid) begin
            model_hist[r.idx] = {model_hist[r.idx][2:0], r.taken};
            if (r.predicted != r.taken) begin
                model_miss = model_miss + `BP_CNT_W'(1);
            end
        end
    endtask

    task automatic apply_resolve(input string line);
        int v0;
        int i0;
        int p0;
        int t0;
        int v1;
        int i1;
        int p1;
        int t1;
        int n;
        n = $sscanf(line, "R %h %h %h %h %h %h %h %h", v0, i0, p0, t0, v1, i1, p1, t1);
        if (n != 8) begin
            abort_run("malformed resolve line in bp_testdata.txt");
        end
        @(posedge clk);
        #1;
        while (resolve_stall) begin
            saw_stall = 1'b1;
            drive_idle();
            @(posedge clk);
            #1;
        end
        res0 = '{valid: v0[0], idx: `BP_IDX_W'(i0), predicted: p0[0], taken: t0[0]};
        res1 = '{valid: v1[0], idx: `BP_IDX_W'(i1), predicted: p1[0], taken: t1[0]};
        miss_pending = {v1[0] & (p1[0] != t1[0]), v0[0] & (p0[0] != t0[0])};
        model_update(res0); // slot order matches the queue
        model_update(res1);
    endtask

    task automatic run_idle(input string line);
        int cycles;
        if ($sscanf(line, "I %d", cycles) != 1) begin
            abort_run("malformed idle line in bp_testdata.txt");
        end
        repeat (cycles) begin
            @(posedge clk);
            #1;
            drive_idle();
        end
    endtask

    task automatic check_ports(input string line);
        int   f;
        int   d0;
        int   d1;
        int   ef;
        int   ed0;
        int   ed1;
        logic model_f;
        logic model_d0;
        logic model_d1;
        if ($sscanf(line, "C %h %h %h %h %h %h", f, d0, d1, ef, ed0, ed1) != 6) begin
            abort_run("malformed check line in bp_testdata.txt");
        end
        @(posedge clk);
        #1;
        drive_idle();
        fetch_idx = `BP_IDX_W'(f);
        dec0_idx  = `BP_IDX_W'(d0);
        dec1_idx  = `BP_IDX_W'(d1);
        #2; // predictions settle well before the next edge
        model_f  = model_predict(model_hist[fetch_idx]);
        model_d0 = model_predict(model_hist[dec0_idx]);
        model_d1 = model_predict(model_hist[dec1_idx]);
        check_value(32'(fetch_pred), 32'(model_f), "fetch_pred vs model");
        check_value(32'(dec0_pred), 32'(model_d0), "dec0_pred vs model");
        check_value(32'(dec1_pred), 32'(model_d1), "dec1_pred vs model");
        check_value(32'(fetch_pred), 32'(ef), "fetch_pred vs file");
        check_value(32'(dec0_pred), 32'(ed0), "dec0_pred vs file");
        check_value(32'(dec1_pred), 32'(ed1), "dec1_pred vs file");
        check_value(32'(mispredict_count), 32'(model_miss), "mispredict_count");
        check_value(32'(resolve_stall), 32'd0, "resolve_stall after drain");
    endtask

    task automatic check_stall_seen(input string line);
        int expect_seen;
        if ($sscanf(line, "S %d", expect_seen) != 1) begin
            abort_run("malformed stall line in bp_testdata.txt");
        end
        check_value(32'(saw_stall), 32'(expect_seen), "resolve_stall seen");
        saw_stall = 1'b0;
    endtask

    // per-slot mispredict pulse one edge after the slots were driven
    always @(posedge clk) begin
        miss_expect  = miss_pending;
        miss_pending = 2'b00;
        #3;
        check_value(32'(mispredict), 32'(miss_expect), "mispredict pulse");
    end

    initial begin
        int    fd;
        string line;
        byte   cmd;
        err_count    = 0;
        loaded       = 1'b0;
        saw_stall    = 1'b0;
        miss_pending = 2'b00;
        model_miss   = '0;
        reset        = 1'b1;
        fetch_idx    = '0;
        dec0_idx     = '0;
        dec1_idx     = '0;
        drive_idle();
        for (int i = 0; i < ENTRIES; i++) begin
            model_hist[i] = '0;
        end

        fd = $fopen("bp_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bp_testdata.txt");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    cmds.push_back(line); // skip blanks and comments
                end
            end
        end
        $fclose(fd);
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        foreach (cmds[k]) begin
            line = cmds[k];
            cmd  = line[0];
            case (cmd)
                "R": apply_resolve(line);
                "I": run_idle(line);
                "C": check_ports(line);
                "S": check_stall_seen(line);
                default: abort_run("unknown command in bp_testdata.txt");
            endcase
        end

        if (err_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "checks failed");
        end
    end

    // limit scales with the number of commands
    initial begin
        wait (loaded);
        repeat (cmds.size() * CYCLES_PER_CMD + RESET_CYCLES) @(posedge clk);
        $display("watchdog expired before the command list finished");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule

// ==== bp_testdata.txt ====
# R v0 idx0 pred0 taken0 v1 idx1 pred1 taken1 (hex)   I idle_cycles (decimal)
# C fetch_idx dec0_idx dec1_idx exp_fetch exp_dec0 exp_dec1 (hex)   S exp_stall_seen
I 4
C 0 1 2 0 0 0
C 3 4 5 0 0 0
C 6 7 8 0 0 0
C 9 a b 0 0 0
C c d e 0 0 0
C f 0 f 0 0 0
R 1 1 0 0 1 1 0 1
R 1 1 1 0 1 1 0 1
R 1 2 1 1 1 3 1 1
R 1 2 0 0 1 3 0 0
R 1 2 0 0 1 3 0 1
R 1 2 0 1 1 3 0 0
I 6
C 1 2 3 1 1 0
S 1
R 1 4 0 0 1 5 0 0
R 1 4 1 1 1 5 1 1
R 1 4 1 1 1 5 0 1
R 1 4 1 0 1 5 1 1
R 0 0 1 0 1 6 1 1
R 1 7 0 0 1 7 0 0
R 1 7 1 1 1 7 0 1
R 0 0 0 0 1 7 1 1
R 1 8 0 1 1 9 0 0
R 1 8 1 1 1 9 0 0
R 1 8 0 0 1 9 1 1
R 1 8 0 0 1 9 1 1
I 8
C 4 5 6 0 1 0
C 7 8 9 1 1 0
C 1 2 3 1 1 0
C a 3 1 0 0 1
S 1

// ==== list.f ====
+incdir+.
bp_pkg.sv
branch_resolve.sv
update_queue.sv
history_table.sv
branch_predictor_top.sv
branch_predictor_props.sv
tb_branch_predictor.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_branch_predictor
FILELIST = list.f
OBJDIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
